//--- src.f
hdl/clk_rst_pkg.sv
hdl/ctrl_regfile.sv
hdl/clock_divider.sv
hdl/reset_sequencer.sv
hdl/clk_rst_ctrl_top.sv
testbench/clk_rst_ctrl_checker.sv
testbench/tb_clk_rst_ctrl.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_clk_rst_ctrl \
  -f src.f \
  -o sim_tb_clk_rst_ctrl

out=$(./obj_dir/sim_tb_clk_rst_ctrl)
echo "$out"

if echo "$out" | grep -q "^Verification passed$"; then
  exit 0
else
  exit 1
fi

//--- testbench/tb_clk_rst_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clk_rst_ctrl;

  import clk_rst_pkg::*;

  localparam int NumClocks = 4;
  localparam int MaxDivisionWidth = 8;
  localparam int DefDiv[NumClocks] = '{2, 3, 4, 7};
  localparam int RstDelay[NumClocks] = '{1, 2, 3, 0};
  localparam int Timeout = 1000;

  logic                 mst_clk_i;
  logic                 control_rst_ni;
  logic                 mst_rst_ni;
  reg_cmd_t             cmd_i;
  logic [NumClocks-1:0] clk_o;
  logic [NumClocks-1:0] rst_no;

  int                   errors;
  int                   tests_run;
  int                   tests_bad;
  logic [31:0]          rng;
  logic [DataWidth-1:0] cur_div [NumClocks];
  int                   rise_cnt [NumClocks];
  int                   win_len [NumClocks];
  bit                   last_rise [NumClocks];

  clk_rst_ctrl_top DUT (
    .mst_clk_i     (mst_clk_i),
    .control_rst_ni(control_rst_ni),
    .mst_rst_ni    (mst_rst_ni),
    .cmd_i         (cmd_i),
    .clk_o         (clk_o),
    .rst_no        (rst_no)
  );

  initial begin
    mst_clk_i = 1'b0;
    forever #2 mst_clk_i = ~mst_clk_i;
  end

  //////////////////////////////
  // Reference model
  //////////////////////////////
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Expected high run in the upper byte and low run in the lower byte
  function automatic logic [2*DataWidth-1:0] ref_runs(input logic [DataWidth-1:0] div);
    logic [DataWidth-1:0] n;
    logic [DataWidth-1:0] high;
    n = div & DataWidth'((1 << MaxDivisionWidth) - 1);
    if (n < 2) begin
      n = 2;
    end
    high = n >> 1;
    return {high, n - high};
  endfunction

  //////////////////////////////
  // Compare tasks
  //////////////////////////////
  task automatic check_div(input string name, input logic [DataWidth-1:0] got,
                           input logic [DataWidth-1:0] exp);
    if (got !== exp) begin
      errors++;
      $display("Error at %0t: %s got %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_rst(input string name, input logic [NumClocks-1:0] got,
                           input logic [NumClocks-1:0] exp);
    if (got !== exp) begin
      errors++;
      $display("Error at %0t: %s got %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      errors++;
      $display("Error at %0t: %s got %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  //////////////////////////////
  // Stimulus and monitors
  //////////////////////////////
  task automatic send_cmd(input cmd_op_e op, input int chan, input logic [DataWidth-1:0] data);
    @(posedge mst_clk_i);
    cmd_i <= '{valid: 1'b1, op: op, chan: ChanIdxWidth'(chan), data: data};
    @(posedge mst_clk_i);
    cmd_i <= '0;
  endtask

  // Runs of the given period counted from the next rising edge
  task automatic measure_period(input int ch, input int which,
                                output logic [DataWidth-1:0] high,
                                output logic [DataWidth-1:0] low);
    logic prev;
    int   n;
    int   hi_n;
    int   lo_n;
    high = '0;
    low  = '0;
    n    = 0;
    @(negedge mst_clk_i);
    prev = clk_o[ch];
    do begin
      @(negedge mst_clk_i);
      n++;
      if (!(clk_o[ch] && !prev)) begin
        prev = clk_o[ch];
      end
    end while (!(clk_o[ch] && !prev) && n < Timeout);
    if (n >= Timeout) begin
      errors++;
      $display("Timed out waiting for a rising edge on clk_o[%0d]", ch);
      return;
    end
    for (int p = 0; p < which; p++) begin
      hi_n = 1;
      lo_n = 0;
      n    = 0;
      while (n < Timeout) begin
        @(negedge mst_clk_i);
        n++;
        if (clk_o[ch] && lo_n > 0) begin
          break;
        end else if (clk_o[ch]) begin
          hi_n++;
        end else begin
          lo_n++;
        end
      end
      if (n >= Timeout) begin
        errors++;
        $display("Timed out measuring a period of clk_o[%0d]", ch);
        return;
      end
      high = DataWidth'(hi_n);
      low  = DataWidth'(lo_n);
    end
  endtask

  // Counts clock edges of the active channels until their rst_no rises
  task automatic watch_release(input logic [NumClocks-1:0] active,
                               input logic [NumClocks-1:0] prev_clk);
    logic [NumClocks-1:0] prev;
    logic [NumClocks-1:0] done;
    int                   n;
    prev = prev_clk;
    done = ~active;
    n    = 0;
    for (int i = 0; i < NumClocks; i++) begin
      rise_cnt[i]  = 0;
      win_len[i]   = 0;
      last_rise[i] = 1'b0;
    end
    while (done != '1 && n < Timeout) begin
      @(negedge mst_clk_i);
      n++;
      for (int i = 0; i < NumClocks; i++) begin
        if (!done[i] && rst_no[i]) begin
          done[i] = 1'b1;
        end else if (!done[i]) begin
          win_len[i]++;
          last_rise[i] = clk_o[i] && !prev[i];
          if (last_rise[i]) begin
            rise_cnt[i]++;
          end
        end
      end
      check_rst("rst_no of other channels", rst_no & ~active, ~active);
      prev = clk_o;
    end
    if (done != '1) begin
      errors++;
      $display("Timed out waiting for rst_no to rise on channels %b", ~done);
    end
  endtask

  task automatic eval_release(input int ch);
    if (RstDelay[ch] == 0) begin
      check_count($sformatf("rst_no[%0d] low cycles", ch), win_len[ch], 1);
    end else begin
      check_count($sformatf("clk_o[%0d] edges before release", ch), rise_cnt[ch],
                  RstDelay[ch]);
      if (!last_rise[ch]) begin
        errors++;
        $display("rst_no[%0d] was not released right after a clock edge", ch);
      end
    end
  endtask

  task automatic finish_test(input string name, input int err_before);
    tests_run++;
    if (errors != err_before) begin
      tests_bad++;
      $display("Test %s: FAIL with %0d errors", name, errors - err_before);
    end else begin
      $display("Test %s: ok", name);
    end
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////
  initial begin
    int                     mark;
    int                     ch;
    logic [DataWidth-1:0]   new_div;
    logic [DataWidth-1:0]   high;
    logic [DataWidth-1:0]   low;
    logic [2*DataWidth-1:0] exp;
    logic [NumClocks-1:0]   prev;
    control_rst_ni = 1'b0;
    mst_rst_ni     = 1'b0;
    cmd_i          = '0;
    errors         = 0;
    tests_run      = 0;
    tests_bad      = 0;
    rng            = 32'h894cc280;
    for (int i = 0; i < NumClocks; i++) begin
      cur_div[i] = DataWidth'(DefDiv[i]);
    end
    repeat (8) @(posedge mst_clk_i);
    control_rst_ni <= 1'b1;

    mark = errors;
    for (int i = 0; i < NumClocks; i++) begin
      measure_period(i, 1, high, low);
      exp = ref_runs(cur_div[i]);
      check_div($sformatf("clk_o[%0d] high run", i), high, exp[2*DataWidth-1:DataWidth]);
      check_div($sformatf("clk_o[%0d] low run", i), low, exp[DataWidth-1:0]);
    end
    finish_test("default division", mark);

    mark = errors;
    @(negedge mst_clk_i);
    check_rst("rst_no", rst_no, '0);
    @(posedge mst_clk_i);
    mst_rst_ni <= 1'b1;
    // Two synchronizer stages and the hold state come first
    repeat (3) begin
      @(negedge mst_clk_i);
      check_rst("rst_no", rst_no, '0);
    end
    prev = clk_o;
    watch_release('1, prev);
    for (int i = 0; i < NumClocks; i++) begin
      eval_release(i);
    end
    finish_test("power-up reset release", mark);

    mark = errors;
    for (int it = 0; it < 8; it++) begin
      rng     = xorshift32(rng);
      ch      = int'(rng[1:0]);
      new_div = (it < 2) ? DataWidth'(it) : rng[15:8];
      send_cmd(OP_SET_DIV, ch, new_div);
      measure_period(ch, 1, high, low);
      exp = ref_runs(cur_div[ch]);
      check_div($sformatf("clk_o[%0d] staged high run", ch), high, exp[2*DataWidth-1:DataWidth]);
      check_div($sformatf("clk_o[%0d] staged low run", ch), low, exp[DataWidth-1:0]);
      send_cmd(OP_COMMIT_DIV, ch, '0);
      measure_period(ch, 2, high, low);
      exp = ref_runs(new_div);
      check_div($sformatf("clk_o[%0d] committed high run", ch), high,
                exp[2*DataWidth-1:DataWidth]);
      check_div($sformatf("clk_o[%0d] committed low run", ch), low, exp[DataWidth-1:0]);
      cur_div[ch] = new_div;
    end
    finish_test("staging and commit", mark);

    mark = errors;
    for (int i = 0; i < NumClocks; i++) begin
      send_cmd(OP_RESET_CHAN, i, '0);
      @(negedge mst_clk_i);
      check_rst("rst_no at command edge", rst_no, '1);
      prev = clk_o;
      watch_release(NumClocks'(1) << i, prev);
      eval_release(i);
    end
    finish_test("channel software reset", mark);

    mark = errors;
    // Reset outputs are watched while the commands go out
    fork
      begin
        send_cmd(OP_SET_DIV, NumClocks, 8'd9);
        send_cmd(OP_COMMIT_DIV, NumClocks, '0);
        send_cmd(OP_RESET_CHAN, 31, '0);
        send_cmd(OP_RESET_CHAN, NumClocks + 1, '0);
      end
      repeat (28) begin
        @(negedge mst_clk_i);
        check_rst("rst_no", rst_no, '1);
      end
    join
    for (int i = 0; i < NumClocks; i++) begin
      measure_period(i, 2, high, low);
      exp = ref_runs(cur_div[i]);
      check_div($sformatf("clk_o[%0d] high run", i), high, exp[2*DataWidth-1:DataWidth]);
      check_div($sformatf("clk_o[%0d] low run", i), low, exp[DataWidth-1:0]);
    end
    check_rst("rst_no", rst_no, '1);
    finish_test("out-of-range commands", mark);

    $display("Tests run: %0d, tests with errors: %0d, check errors: %0d",
             tests_run, tests_bad, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/clk_rst_ctrl_checker.sv
`timescale 1ns/10ps
`default_nettype none

module clk_rst_ctrl_checker #(
  parameter int NumClocks = 4
) (
  input logic                    mst_clk_i,
  input logic                    control_rst_n_d2_mst_clk,
  input logic [NumClocks-1:0]    clk_o,
  input logic [NumClocks-1:0]    rst_no,
  input logic [NumClocks-1:0]    chan_rise,
  input clk_rst_pkg::chan_ctrl_t chan_ctrl [NumClocks]
);

  // Outputs parked low during the control reset
  a_reset_low: assert property (@(posedge mst_clk_i)
    !control_rst_n_d2_mst_clk |-> (clk_o == '0) && (rst_no == '0))
    else $error("clk_o or rst_no not low during control reset");

  //////////////////////////////
  // Per channel
  //////////////////////////////
  for (genvar i = 0; i < NumClocks; i++) begin : gen_chan
    a_rise_edge: assert property (@(posedge mst_clk_i)
      disable iff (!control_rst_n_d2_mst_clk)
      chan_rise[i] == (clk_o[i] && !$past(clk_o[i])))
      else $error("rise pulse of channel %0d off its clock edge", i);

    a_commit_pulse: assert property (@(posedge mst_clk_i)
      disable iff (!control_rst_n_d2_mst_clk)
      chan_ctrl[i].div_commit |=> !chan_ctrl[i].div_commit)
      else $error("commit pulse of channel %0d lasted two cycles", i);

    a_req_pulse: assert property (@(posedge mst_clk_i)
      disable iff (!control_rst_n_d2_mst_clk)
      chan_ctrl[i].rst_req |=> !chan_ctrl[i].rst_req)
      else $error("reset request of channel %0d lasted two cycles", i);
  end

endmodule

bind clk_rst_ctrl_top clk_rst_ctrl_checker #(
  .NumClocks(NumClocks)
) i_checker (
  .mst_clk_i               (mst_clk_i),
  .control_rst_n_d2_mst_clk(control_rst_n_d2_mst_clk),
  .clk_o                   (clk_o),
  .rst_no                  (rst_no),
  .chan_rise               (chan_rise),
  .chan_ctrl               (chan_ctrl)
);

`default_nettype wire

//--- hdl/clk_rst_ctrl_top.sv
`timescale 1ns/10ps
`default_nettype none

module clk_rst_ctrl_top #(
  parameter int NumClocks = 4,
  parameter int MaxDivisionWidth = 8,
  parameter int DefaultDivision[NumClocks] = '{2, 3, 4, 7},
  parameter int ResetDelays[NumClocks] = '{1, 2, 3, 0}
) (
  input  logic                 mst_clk_i,
  input  logic                 control_rst_ni,
  input  logic                 mst_rst_ni,
  input  clk_rst_pkg::reg_cmd_t cmd_i,
  output logic [NumClocks-1:0] clk_o,
  output logic [NumClocks-1:0] rst_no
);

  import clk_rst_pkg::*;

  //////////////////////////////
  // Reset synchronizers
  //////////////////////////////
  logic control_rst_n_d1_mst_clk;
  logic control_rst_n_d2_mst_clk;
  logic mst_rst_n_d1_mst_clk;
  logic mst_rst_n_d2_mst_clk;

  // Asserts asynchronously and releases two edges later
  always_ff @(posedge mst_clk_i or negedge control_rst_ni) begin
    if (!control_rst_ni) begin
      control_rst_n_d1_mst_clk <= 1'b0;
      control_rst_n_d2_mst_clk <= 1'b0;
    end else begin
      control_rst_n_d1_mst_clk <= 1'b1;
      control_rst_n_d2_mst_clk <= control_rst_n_d1_mst_clk;
    end
  end

  // Global channel reset that only holds the sequencers
  always_ff @(posedge mst_clk_i or negedge control_rst_n_d2_mst_clk) begin
    if (!control_rst_n_d2_mst_clk) begin
      mst_rst_n_d1_mst_clk <= 1'b0;
      mst_rst_n_d2_mst_clk <= 1'b0;
    end else begin
      mst_rst_n_d1_mst_clk <= mst_rst_ni;
      mst_rst_n_d2_mst_clk <= mst_rst_n_d1_mst_clk;
    end
  end

  //////////////////////////////
  // Command decode
  //////////////////////////////
  chan_ctrl_t chan_ctrl [NumClocks];
  logic [NumClocks-1:0] chan_rise;

  ctrl_regfile #(
    .NumClocks(NumClocks)
  ) i_ctrl_regfile (
    .mst_clk_i               (mst_clk_i),
    .control_rst_n_d2_mst_clk(control_rst_n_d2_mst_clk),
    .cmd_i                   (cmd_i),
    .chan_ctrl_o             (chan_ctrl)
  );

  //////////////////////////////
  // Channels
  //////////////////////////////
  for (genvar i = 0; i < NumClocks; i++) begin : gen_chan
    clock_divider #(
      .MaxDivisionWidth(MaxDivisionWidth),
      .DefaultDivision (DefaultDivision[i])
    ) i_clock_divider (
      .mst_clk_i               (mst_clk_i),
      .control_rst_n_d2_mst_clk(control_rst_n_d2_mst_clk),
      .div_value_i             (chan_ctrl[i].div_value),
      .div_commit_i            (chan_ctrl[i].div_commit),
      .clk_o                   (clk_o[i]),
      .rise_o                  (chan_rise[i])
    );

    reset_sequencer #(
      .ResetDelay(ResetDelays[i])
    ) i_reset_sequencer (
      .mst_clk_i               (mst_clk_i),
      .control_rst_n_d2_mst_clk(control_rst_n_d2_mst_clk),
      .glob_rst_n_i            (mst_rst_n_d2_mst_clk),
      .rst_req_i               (chan_ctrl[i].rst_req),
      .rise_i                  (chan_rise[i]),
      .rst_no                  (rst_no[i])
    );
  end

endmodule

`default_nettype wire

//--- hdl/reset_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module reset_sequencer #(
  parameter int ResetDelay = 1
) (
  input  logic mst_clk_i,
  input  logic control_rst_n_d2_mst_clk,
  input  logic glob_rst_n_i,
  input  logic rst_req_i,
  input  logic rise_i,
  output logic rst_no
);

  import clk_rst_pkg::*;

  localparam int CntWidth = (ResetDelay > 0) ? $clog2(ResetDelay + 1) : 1;

  rst_state_e          state_q;
  rst_state_e          state_d;
  logic [CntWidth-1:0] cnt_q;
  logic [CntWidth-1:0] cnt_d;
  logic [CntWidth:0]   cnt_sum;
  logic                rst_n_q;

  // Counts the rise pulse of the current cycle too
  assign cnt_sum = {1'b0, cnt_q} + rise_i;

  //////////////////////////////
  // Next state
  //////////////////////////////
  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    if (!glob_rst_n_i) begin
      state_d = RST_HOLD;
      cnt_d   = '0;
    end else if (rst_req_i) begin
      // Restart from any state
      state_d = RST_COUNT;
      cnt_d   = '0;
    end else begin
      unique case (state_q)
        RST_HOLD: begin
          state_d = RST_COUNT;
          cnt_d   = '0;
        end
        RST_COUNT: begin
          if (cnt_sum >= ResetDelay) begin
            state_d = RST_DONE;
          end else begin
            cnt_d = cnt_sum[CntWidth-1:0];
          end
        end
        RST_DONE: ;
        default: state_d = RST_HOLD;
      endcase
    end
  end

  always_ff @(posedge mst_clk_i or negedge control_rst_n_d2_mst_clk) begin
    if (!control_rst_n_d2_mst_clk) begin
      state_q <= RST_HOLD;
      cnt_q   <= '0;
      rst_n_q <= 1'b0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
      rst_n_q <= (state_d == RST_DONE);
    end
  end

  assign rst_no = rst_n_q;

endmodule

`default_nettype wire

//--- hdl/clock_divider.sv
`timescale 1ns/10ps
`default_nettype none

module clock_divider #(
  parameter int MaxDivisionWidth = 8,
  parameter int DefaultDivision = 2
) (
  input  logic                              mst_clk_i,
  input  logic                              control_rst_n_d2_mst_clk,
  input  logic [clk_rst_pkg::DataWidth-1:0] div_value_i,
  input  logic                              div_commit_i,
  output logic                              clk_o,
  output logic                              rise_o
);

  // Divide by 0 and 1 run as divide by 2
  function automatic logic [MaxDivisionWidth-1:0] eff_div(
    input logic [MaxDivisionWidth-1:0] raw
  );
    eff_div = (raw < 2) ? MaxDivisionWidth'(2) : raw;
  endfunction

  localparam logic [MaxDivisionWidth-1:0] DefaultRaw =
    DefaultDivision[MaxDivisionWidth-1:0];
  localparam logic [MaxDivisionWidth-1:0] DefaultEff = eff_div(DefaultRaw);

  logic [MaxDivisionWidth-1:0] div_q;
  logic [MaxDivisionWidth-1:0] div_d;
  logic [MaxDivisionWidth-1:0] shadow_q;
  logic [MaxDivisionWidth-1:0] cnt_q;
  logic [MaxDivisionWidth-1:0] cnt_d;
  logic                        pending_q;
  logic                        last_cnt;
  logic                        clk_d;
  logic                        clk_q;
  logic                        rise_q;

  //////////////////////////////
  // Period counter
  //////////////////////////////
  assign last_cnt = (cnt_q == div_q - 1'b1);

  always_comb begin
    div_d = div_q;
    cnt_d = cnt_q + 1'b1;
    if (last_cnt) begin
      cnt_d = '0;
      // New divisor only at a period start
      if (pending_q) begin
        div_d = shadow_q;
      end
    end
    // High for the first half rounded down
    clk_d = (cnt_d < (div_d >> 1));
  end

  // Reset parks the counter at the end of a period
  always_ff @(posedge mst_clk_i or negedge control_rst_n_d2_mst_clk) begin
    if (!control_rst_n_d2_mst_clk) begin
      div_q  <= DefaultEff;
      cnt_q  <= DefaultEff - 1'b1;
      clk_q  <= 1'b0;
      rise_q <= 1'b0;
    end else begin
      div_q  <= div_d;
      cnt_q  <= cnt_d;
      clk_q  <= clk_d;
      rise_q <= clk_d && !clk_q;
    end
  end

  //////////////////////////////
  // Pending divisor
  //////////////////////////////
  always_ff @(posedge mst_clk_i or negedge control_rst_n_d2_mst_clk) begin
    if (!control_rst_n_d2_mst_clk) begin
      pending_q <= 1'b0;
    end else if (div_commit_i) begin
      pending_q <= 1'b1;
    end else if (last_cnt) begin
      pending_q <= 1'b0;
    end
  end

  always_ff @(posedge mst_clk_i or negedge control_rst_n_d2_mst_clk) begin
    if (!control_rst_n_d2_mst_clk) begin
      shadow_q <= DefaultEff;
    end else if (div_commit_i) begin
      shadow_q <= eff_div(div_value_i[MaxDivisionWidth-1:0]);
    end
  end

  assign clk_o  = clk_q;
  assign rise_o = rise_q;

endmodule

`default_nettype wire

//--- hdl/ctrl_regfile.sv
`timescale 1ns/10ps
`default_nettype none

module ctrl_regfile #(
  parameter int NumClocks = 4
) (
  input  logic                    mst_clk_i,
  input  logic                    control_rst_n_d2_mst_clk,
  input  clk_rst_pkg::reg_cmd_t   cmd_i,
  output clk_rst_pkg::chan_ctrl_t chan_ctrl_o [NumClocks]
);

  import clk_rst_pkg::*;

  logic in_range;
  logic do_set_div;
  logic do_commit;
  logic do_reset;

  // Commands beyond the last channel are dropped
  assign in_range = (cmd_i.chan < NumClocks);

  always_comb begin
    do_set_div = 1'b0;
    do_commit  = 1'b0;
    do_reset   = 1'b0;
    if (cmd_i.valid && in_range) begin
      unique case (cmd_i.op)
        OP_SET_DIV:    do_set_div = 1'b1;
        OP_COMMIT_DIV: do_commit  = 1'b1;
        OP_RESET_CHAN: do_reset   = 1'b1;
        default:       ;
      endcase
    end
  end

  //////////////////////////////
  // Per-channel registers
  //////////////////////////////
  for (genvar i = 0; i < NumClocks; i++) begin : gen_chan
    logic                 sel;
    logic [DataWidth-1:0] div_value_q;
    logic                 div_commit_q;
    logic                 rst_req_q;

    assign sel = (cmd_i.chan == ChanIdxWidth'(i));

    always_ff @(posedge mst_clk_i or negedge control_rst_n_d2_mst_clk) begin
      if (!control_rst_n_d2_mst_clk) begin
        div_value_q  <= '0;
        div_commit_q <= 1'b0;
        rst_req_q    <= 1'b0;
      end else begin
        // Pulses last exactly one cycle
        div_commit_q <= sel && do_commit;
        rst_req_q    <= sel && do_reset;
        if (sel && do_set_div) begin
          div_value_q <= cmd_i.data;
        end
      end
    end

    assign chan_ctrl_o[i].div_value  = div_value_q;
    assign chan_ctrl_o[i].div_commit = div_commit_q;
    assign chan_ctrl_o[i].rst_req    = rst_req_q;
  end

endmodule

`default_nettype wire

//--- hdl/clk_rst_pkg.sv
`default_nettype none

package clk_rst_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////
  // Command data word with divisors in its low bits
  localparam int DataWidth = 8;
  // Up to 32 channels
  localparam int ChanIdxWidth = 5;

  //////////////////////////////
  // Command strobe
  //////////////////////////////
  typedef enum logic [1:0] {
    OP_NOP        = 2'd0,
    OP_SET_DIV    = 2'd1,
    OP_COMMIT_DIV = 2'd2,
    OP_RESET_CHAN = 2'd3
  } cmd_op_e;

  typedef struct packed {
    logic                    valid;
    cmd_op_e                 op;
    logic [ChanIdxWidth-1:0] chan;
    logic [DataWidth-1:0]    data;
  } reg_cmd_t;

  // Per-channel control whose two flags are single-cycle pulses
  typedef struct packed {
    logic [DataWidth-1:0] div_value;
    logic                 div_commit;
    logic                 rst_req;
  } chan_ctrl_t;

  // Reset sequencer states
  typedef enum logic [1:0] {
    RST_HOLD  = 2'd0,
    RST_COUNT = 2'd1,
    RST_DONE  = 2'd2
  } rst_state_e;

endpackage

`default_nettype wire
